// ==== build.f ====
+incdir+.
mmu_pkg.sv
mmu_dispatch.sv
load_queue.sv
store_queue.sv
load_unit.sv
data_mem.sv
mmu_top.sv
mmu_chk.sv
tb_mmu.sv

// ==== data_mem.sv ====
/*
 * Word-addressed data memory
 * Synchronous write, registered read every cycle
 */

`timescale 1ns/1ns
`default_nettype none

`include "mmu_cfg.svh"

module data_mem import mmu_pkg::*; (
    input  wire logic               clk,
    input  mem_write_t              wr_i,
    input  word_addr_t              rd_addr_i,
    output logic [`MMU_XLEN-1:0]    rd_data_o
);

    localparam int AW = $clog2(`MMU_MEM_WORDS);

    logic [`MMU_XLEN-1:0] mem [`MMU_MEM_WORDS];

    // Read returns the old word when a write hits the same address
    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            mem[wr_i.addr[AW-1:0]] <= wr_i.data;
        end
        rd_data_o <= mem[rd_addr_i[AW-1:0]];
    end

endmodule

`default_nettype wire

// ==== load_queue.sv ====
/*
 * Load queue
 * Circular buffer of pending loads in program order
 */

`timescale 1ns/1ns
`default_nettype none

`include "mmu_cfg.svh"

module load_queue import mmu_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   push_i,
    input  lq_entry_t   entry_i,
    output logic        full_o,
    output logic        head_valid_o,
    output lq_entry_t   head_o,
    input  wire logic   pop_i
);

    localparam int DEPTH = `MMU_LQ_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = IDX_W + 1;

    lq_entry_t          entries [DEPTH];
    logic [IDX_W-1:0]   head_q;
    logic [IDX_W-1:0]   tail_q;
    logic [CNT_W-1:0]   count_q;

    // --------------------
    // Pointers and count
    // --------------------

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop_i) begin
                head_q <= head_q + 1'b1;
            end
            // Push and pop together leave the count alone
            if (push_i && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (pop_i && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // --------------------
    // Entry storage
    // --------------------

    always_ff @(posedge clk) begin
        if (push_i) begin
            entries[tail_q] <= entry_i;
        end
    end

    assign full_o       = (count_q == CNT_W'(DEPTH));
    assign head_valid_o = (count_q != '0);
    assign head_o       = entries[head_q];

endmodule

`default_nettype wire

// ==== load_unit.sv ====
/*
 * Load issue and result stage
 * In-order issue, forward or memory data select, held result register
 */

`timescale 1ns/1ns
`default_nettype none

`include "mmu_cfg.svh"

module load_unit import mmu_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               head_valid_i,
    input  lq_entry_t               head_i,
    output logic                    pop_o,
    output word_addr_t              fwd_addr_o,
    output sq_ptr_t                 fwd_limit_o,
    input  wire logic               fwd_hit_i,
    input  wire logic [`MMU_XLEN-1:0] fwd_data_i,
    output word_addr_t              rd_addr_o,
    input  wire logic [`MMU_XLEN-1:0] rd_data_i,
    output logic                    result_valid_o,
    output load_result_t            result_o,
    input  wire logic               result_ready_i
);

    logic                   valid_q;
    logic                   use_reg_q;   // Result comes from data_q, not the memory port
    logic [`MMU_TAG_W-1:0]  tag_q;
    logic [`MMU_XLEN-1:0]   data_q;
    logic                   issue;
    logic                   hold;

    // Result stage empty or emptied this cycle
    assign issue = head_valid_i && (!valid_q || result_ready_i);
    assign hold  = valid_q && !result_ready_i;
    assign pop_o = issue;

    // Search and read both use the head load of this cycle
    assign fwd_addr_o  = head_i.addr;
    assign fwd_limit_o = head_i.snap;
    assign rd_addr_o   = head_i.addr;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q   <= 1'b0;
            use_reg_q <= 1'b0;
        end else begin
            if (issue) begin
                valid_q   <= 1'b1;
                use_reg_q <= fwd_hit_i;
            end else if (valid_q && result_ready_i) begin
                valid_q <= 1'b0;
            end else if (hold) begin
                // Memory data is parked in data_q below
                use_reg_q <= 1'b1;
            end
        end
    end

    // Memory read data only lasts one cycle, keep it while stalled
    always_ff @(posedge clk) begin
        if (issue) begin
            tag_q  <= head_i.tag;
            data_q <= fwd_data_i;
        end else if (hold && !use_reg_q) begin
            data_q <= rd_data_i;
        end
    end

    assign result_valid_o = valid_q;
    assign result_o.tag   = tag_q;
    assign result_o.data  = use_reg_q ? data_q : rd_data_i;

endmodule

`default_nettype wire

// ==== mmu_cfg.svh ====
/*
 * Sizing macros for the memory unit
 * Queue depths, data and tag widths, data memory size
 */

`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

// --------------------
// Datapath widths
// --------------------

// Data and address width
`define MMU_XLEN 32

// Reorder-buffer tag width
`define MMU_TAG_W 6

// --------------------
// Queue sizes
// --------------------

`define MMU_LQ_DEPTH 8
`define MMU_SQ_DEPTH 8

// Index bits of the store queue plus one wrap bit
`define MMU_SQ_PTR_W 4

// Data memory size in 32-bit words
`define MMU_MEM_WORDS 256

`endif

// ==== mmu_chk.sv ====
/*
 * Queue checker bound into the load and store queues
 * Push while full, pop while empty, commit write while empty
 */

`timescale 1ns/1ns
`default_nettype none

module mmu_chk (
    input wire logic clk,
    input wire logic rst,
    input wire logic push_i,
    input wire logic full_i,
    input wire logic pop_i,
    input wire logic wr_en_i
);

    int violations = 0;
    int level;

    // Occupancy rebuilt from the push and pop strobes alone
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            level <= 0;
        end else begin
            level <= level + (push_i ? 1 : 0) - (pop_i ? 1 : 0);
        end
    end

    // Dispatch holds back when the target queue is full
    push_full_a: assert property (@(posedge clk) disable iff (!rst) !(push_i && full_i))
        else begin
            violations++;
            $error("push into a full queue");
        end

    pop_empty_a: assert property (@(posedge clk) disable iff (!rst) !(pop_i && level == 0))
        else begin
            violations++;
            $error("pop from an empty queue");
        end

    // Commits on an empty store queue never reach memory
    write_empty_a: assert property (@(posedge clk) disable iff (!rst) !(wr_en_i && level == 0))
        else begin
            violations++;
            $error("memory write from an empty store queue");
        end

endmodule

bind load_queue mmu_chk u_chk (
    .clk     (clk),
    .rst     (rst),
    .push_i  (push_i),
    .full_i  (full_o),
    .pop_i   (pop_i),
    .wr_en_i (1'b0)
);

bind store_queue mmu_chk u_chk (
    .clk     (clk),
    .rst     (rst),
    .push_i  (push_i),
    .full_i  (full_o),
    .pop_i   (drain),
    .wr_en_i (mem_write_o.en)
);

`default_nettype wire

// ==== mmu_dispatch.sv ====
/*
 * Dispatch stage of the memory unit
 * Effective address, queue routing and dispatch ready
 */

`timescale 1ns/1ns
`default_nettype none

`include "mmu_cfg.svh"

module mmu_dispatch import mmu_pkg::*; (
    input  wire logic          dispatch_valid_i,
    input  dispatch_req_t      dispatch_req_i,
    output logic               dispatch_ready_o,
    input  wire logic          lq_full_i,
    input  wire logic          sq_full_i,
    input  sq_ptr_t            sq_tail_i,
    output logic               lq_push_o,
    output lq_entry_t          lq_entry_o,
    output logic               sq_push_o,
    output sq_entry_t          sq_entry_o
);

    logic [`MMU_XLEN-1:0] eff_addr;
    logic                 is_load;

    // Byte address, only the word part is kept
    assign eff_addr = dispatch_req_i.base + dispatch_req_i.offset;
    assign is_load  = (dispatch_req_i.op == OP_LOAD);

    // Ready follows the queue this op needs
    assign dispatch_ready_o = is_load ? !lq_full_i : !sq_full_i;

    assign lq_push_o = dispatch_valid_i && is_load && !lq_full_i;
    assign sq_push_o = dispatch_valid_i && !is_load && !sq_full_i;

    // Load remembers how many stores are older than itself
    assign lq_entry_o.tag  = dispatch_req_i.tag;
    assign lq_entry_o.addr = eff_addr[`MMU_XLEN-1:2];
    assign lq_entry_o.snap = sq_tail_i;

    assign sq_entry_o.addr = eff_addr[`MMU_XLEN-1:2];
    assign sq_entry_o.data = dispatch_req_i.data;

endmodule

`default_nettype wire

// ==== mmu_pkg.sv ====
/*
 * Shared types of the memory unit
 * Operation enum, queue entries, memory write and load result structs
 */

`default_nettype none

`include "mmu_cfg.svh"

package mmu_pkg;

    // Operation kinds
    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } mem_op_e;

    // Word address, low two byte bits already dropped
    typedef logic [`MMU_XLEN-3:0] word_addr_t;

    // Store-queue pointer, top bit is the wrap bit
    typedef logic [`MMU_SQ_PTR_W-1:0] sq_ptr_t;

    // One operation from dispatch
    typedef struct packed {
        mem_op_e                 op;
        logic [`MMU_TAG_W-1:0]   tag;
        logic [`MMU_XLEN-1:0]    base;
        logic [`MMU_XLEN-1:0]    offset;
        logic [`MMU_XLEN-1:0]    data;
    } dispatch_req_t;

    // --------------------
    // Queue entries
    // --------------------

    typedef struct packed {
        logic [`MMU_TAG_W-1:0]   tag;
        word_addr_t              addr;
        sq_ptr_t                 snap;   // Store-queue tail at dispatch
    } lq_entry_t;

    typedef struct packed {
        word_addr_t              addr;
        logic [`MMU_XLEN-1:0]    data;
    } sq_entry_t;

    // --------------------
    // Memory and result
    // --------------------

    typedef struct packed {
        logic                    en;
        word_addr_t              addr;
        logic [`MMU_XLEN-1:0]    data;
    } mem_write_t;

    typedef struct packed {
        logic [`MMU_TAG_W-1:0]   tag;
        logic [`MMU_XLEN-1:0]    data;
    } load_result_t;

endpackage

`default_nettype wire

// ==== mmu_top.sv ====
/*
 * Memory unit top level
 * Dispatch, load and store queues, load unit, data memory
 */

`timescale 1ns/1ns
`default_nettype none

`include "mmu_cfg.svh"

module mmu_top import mmu_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       dispatch_valid_i,
    input  dispatch_req_t   dispatch_req_i,
    output logic            dispatch_ready_o,
    input  wire logic       commit_i,
    output logic            result_valid_o,
    output load_result_t    result_o,
    input  wire logic       result_ready_i
);

    // --------------------
    // Internal wires
    // --------------------

    logic                   lq_push;
    lq_entry_t              lq_entry;
    logic                   lq_full;
    logic                   lq_head_valid;
    lq_entry_t              lq_head;
    logic                   lq_pop;
    logic                   sq_push;
    sq_entry_t              sq_entry;
    logic                   sq_full;
    sq_ptr_t                sq_tail;
    mem_write_t             mem_write;
    word_addr_t             fwd_addr;
    sq_ptr_t                fwd_limit;
    logic                   fwd_hit;
    logic [`MMU_XLEN-1:0]   fwd_data;
    word_addr_t             rd_addr;
    logic [`MMU_XLEN-1:0]   rd_data;

    mmu_dispatch u_dispatch (
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_req_i   (dispatch_req_i),
        .dispatch_ready_o (dispatch_ready_o),
        .lq_full_i        (lq_full),
        .sq_full_i        (sq_full),
        .sq_tail_i        (sq_tail),
        .lq_push_o        (lq_push),
        .lq_entry_o       (lq_entry),
        .sq_push_o        (sq_push),
        .sq_entry_o       (sq_entry)
    );

    load_queue u_load_queue (
        .clk          (clk),
        .rst          (rst),
        .push_i       (lq_push),
        .entry_i      (lq_entry),
        .full_o       (lq_full),
        .head_valid_o (lq_head_valid),
        .head_o       (lq_head),
        .pop_i        (lq_pop)
    );

    store_queue u_store_queue (
        .clk         (clk),
        .rst         (rst),
        .push_i      (sq_push),
        .entry_i     (sq_entry),
        .full_o      (sq_full),
        .tail_o      (sq_tail),
        .commit_i    (commit_i),
        .mem_write_o (mem_write),
        .fwd_addr_i  (fwd_addr),
        .fwd_limit_i (fwd_limit),
        .fwd_hit_o   (fwd_hit),
        .fwd_data_o  (fwd_data)
    );

    load_unit u_load_unit (
        .clk            (clk),
        .rst            (rst),
        .head_valid_i   (lq_head_valid),
        .head_i         (lq_head),
        .pop_o          (lq_pop),
        .fwd_addr_o     (fwd_addr),
        .fwd_limit_o    (fwd_limit),
        .fwd_hit_i      (fwd_hit),
        .fwd_data_i     (fwd_data),
        .rd_addr_o      (rd_addr),
        .rd_data_i      (rd_data),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .result_ready_i (result_ready_i)
    );

    data_mem u_data_mem (
        .clk       (clk),
        .wr_i      (mem_write),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Compile and run the memory unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing -Wno-fatal --top-module tb_mmu \
    -f build.f --Mdir obj_dir -o tb_mmu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_mmu_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
    exit 0
fi
exit 1

// ==== store_queue.sv ====
/*
 * Store queue
 * Program-order stores, commit drain into memory, forwarding search
 */

`timescale 1ns/1ns
`default_nettype none

`include "mmu_cfg.svh"

module store_queue import mmu_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               push_i,
    input  sq_entry_t               entry_i,
    output logic                    full_o,
    output sq_ptr_t                 tail_o,
    input  wire logic               commit_i,
    output mem_write_t              mem_write_o,
    input  word_addr_t              fwd_addr_i,
    input  sq_ptr_t                 fwd_limit_i,
    output logic                    fwd_hit_o,
    output logic [`MMU_XLEN-1:0]    fwd_data_o
);

    localparam int DEPTH = `MMU_SQ_DEPTH;
    localparam int IDX_W = `MMU_SQ_PTR_W - 1;

    sq_entry_t  entries [DEPTH];
    sq_ptr_t    head_q;
    sq_ptr_t    tail_q;
    sq_ptr_t    occupancy;
    sq_ptr_t    fwd_dist;
    logic       empty;
    logic       drain;
    logic       limit_in_range;

    // Wrap bit tells full from empty
    assign occupancy = tail_q - head_q;
    assign empty     = (occupancy == '0);
    assign full_o    = (occupancy == sq_ptr_t'(DEPTH));
    assign tail_o    = tail_q;

    // Commit pulses on an empty queue are dropped
    assign drain = commit_i && !empty;

    // --------------------
    // Pointers
    // --------------------

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (push_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (drain) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            entries[tail_q[IDX_W-1:0]] <= entry_i;
        end
    end

    // Head entry goes to memory on the commit edge
    assign mem_write_o.en   = drain;
    assign mem_write_o.addr = entries[head_q[IDX_W-1:0]].addr;
    assign mem_write_o.data = entries[head_q[IDX_W-1:0]].data;

    // --------------------
    // Forwarding search
    // --------------------

    // Stores older than the load sit between head and the snapshot.
    // Once the head has moved past the snapshot, all of them are in memory
    assign fwd_dist       = fwd_limit_i - head_q;
    assign limit_in_range = (fwd_dist <= occupancy);

    always_comb begin
        sq_ptr_t scan_ptr;

        fwd_hit_o  = 1'b0;
        fwd_data_o = '0;
        // Oldest first, so the last match is the youngest
        for (int i = 0; i < DEPTH; i++) begin
            scan_ptr = head_q + sq_ptr_t'(i);
            if (limit_in_range && (sq_ptr_t'(i) < fwd_dist) &&
                (entries[scan_ptr[IDX_W-1:0]].addr == fwd_addr_i)) begin
                fwd_hit_o  = 1'b1;
                fwd_data_o = entries[scan_ptr[IDX_W-1:0]].data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_mmu.sv ====
/*
 * Testbench for the memory unit top level
 * Clock, reset, random stimulus, program-order memory model, result checks
 */

`timescale 1ns/1ns
`default_nettype none

`include "mmu_cfg.svh"

module tb_mmu import mmu_pkg::*; ();

    localparam int WAIT_LIMIT = 200;
    localparam int RAND_OPS   = 400;

    logic           clk;
    logic           rst;
    logic           dispatch_valid_i;
    dispatch_req_t  dispatch_req_i;
    logic           dispatch_ready_o;
    logic           commit_i;
    logic           result_valid_o;
    load_result_t   result_o;
    logic           result_ready_i;

    // Values applied on the next falling edge
    logic           drv_valid;
    dispatch_req_t  drv_req;
    logic           drv_commit;
    logic           drv_ready;
    logic           rand_mode;

    // Program-order model of the 16-word window
    logic [31:0]            model_mem [16];
    logic                   written [16];
    load_result_t           exp_q [$];
    int                     pending;
    logic [`MMU_TAG_W-1:0]  next_tag;

    integer         seed;
    int             errors;
    int             checks;
    int             tests;
    int             failed_tests;
    int             loads_sent;
    int             results_seen;
    logic           accepted;
    logic           held_valid;
    load_result_t   held_result;

    mmu_top u_mmu_top (
        .clk              (clk),
        .rst              (rst),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_req_i   (dispatch_req_i),
        .dispatch_ready_o (dispatch_ready_o),
        .commit_i         (commit_i),
        .result_valid_o   (result_valid_o),
        .result_o         (result_o),
        .result_ready_i   (result_ready_i)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[ERROR] %0t: %s got %0h expected %0h", $time, what, got, want);
        end
    endtask

    // --------------------
    // One clock cycle
    // --------------------

    // Drive on the falling edge, sample 1 ns later while everything is settled
    task automatic tick();
        logic [31:0]    eff;
        load_result_t   want;
        @(negedge clk);
        if (rand_mode) begin
            drv_commit = ($random(seed) & 1) != 0;
            drv_ready  = ($random(seed) & 3) != 0;
        end
        dispatch_valid_i = drv_valid;
        dispatch_req_i   = drv_req;
        commit_i         = drv_commit && (pending > 0);
        result_ready_i   = drv_ready;
        #1;
        accepted = dispatch_valid_i && dispatch_ready_o;
        if (accepted) begin
            eff = dispatch_req_i.base + dispatch_req_i.offset;
            if (dispatch_req_i.op == OP_STORE) begin
                model_mem[eff[5:2]] = dispatch_req_i.data;
                written[eff[5:2]]   = 1'b1;
                pending++;
            end else begin
                want.tag  = dispatch_req_i.tag;
                want.data = model_mem[eff[5:2]];
                exp_q.push_back(want);
                loads_sent++;
            end
        end
        if (commit_i) begin
            pending--;
        end
        // A stalled result must not move
        if (held_valid) begin
            check_value("held valid", result_valid_o, 1);
            check_value("held result", result_o, held_result);
        end
        held_valid  = result_valid_o && !result_ready_i;
        held_result = result_o;
        if (result_valid_o && result_ready_i) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("[ERROR] %0t: result tag %0h with no load outstanding",
                         $time, result_o.tag);
            end else begin
                want = exp_q.pop_front();
                check_value("load tag", result_o.tag, want.tag);
                check_value("load data", result_o.data, want.data);
                results_seen++;
            end
        end
    endtask

    // --------------------
    // Stimulus helpers
    // --------------------

    // Base and offset straddle a borrow, low byte bits are random
    task automatic present_op(input mem_op_e op, input int w, input logic [31:0] data);
        logic [31:0] low;
        low            = $random(seed) & 3;
        drv_req.op     = op;
        drv_req.tag    = next_tag;
        drv_req.base   = 32'h0000_1040 + 32'(w << 2) + low;
        drv_req.offset = 32'hFFFF_FFC0;
        drv_req.data   = data;
        drv_valid      = 1'b1;
        next_tag       = next_tag + 1'b1;
    endtask

    task automatic wait_accept();
        int guard = 0;
        tick();
        while (!accepted) begin
            if (guard == WAIT_LIMIT) begin
                $display("Timeout: dispatch was never accepted");
                $display("FAIL: see errors above");
                $finish;
            end
            guard++;
            tick();
        end
        drv_valid = 1'b0;
    endtask

    task automatic send_op(input mem_op_e op, input int w, input logic [31:0] data);
        present_op(op, w, data);
        wait_accept();
    endtask

    task automatic wait_results();
        int guard = 0;
        while (exp_q.size() != 0) begin
            if (guard == 5 * WAIT_LIMIT) begin
                $display("Timeout: %0d load results never arrived", exp_q.size());
                $display("FAIL: see errors above");
                $finish;
            end
            guard++;
            tick();
        end
    endtask

    task automatic wait_result_valid();
        int guard = 0;
        while (!result_valid_o) begin
            if (guard == WAIT_LIMIT) begin
                $display("Timeout: result valid never rose");
                $display("FAIL: see errors above");
                $finish;
            end
            guard++;
            tick();
        end
    endtask

    task automatic drain_commits();
        int guard = 0;
        drv_commit = 1'b1;
        while (pending > 0) begin
            if (guard == WAIT_LIMIT) begin
                $display("Timeout: store queue did not drain");
                $display("FAIL: see errors above");
                $finish;
            end
            guard++;
            tick();
        end
        drv_commit = 1'b0;
    endtask

    task automatic end_test(input string name, input int mark);
        tests++;
        if (errors != mark) begin
            failed_tests++;
        end
        $display("test %-28s %s", name, (errors == mark) ? "ok" : "failed");
    endtask

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        int             mark;
        int             w;
        int             chk_fails;
        logic [31:0]    d;
        load_result_t   held;

        seed = 69897;
        clk = 1'b0;
        rst = 1'b0;
        dispatch_valid_i = 1'b0;
        dispatch_req_i = '0;
        commit_i = 1'b0;
        result_ready_i = 1'b1;
        drv_valid = 1'b0;
        drv_req = '0;
        drv_commit = 1'b0;
        drv_ready = 1'b1;
        rand_mode = 1'b0;
        for (int i = 0; i < 16; i++) begin
            model_mem[i] = '0;
            written[i] = 1'b0;
        end
        pending = 0;
        next_tag = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        failed_tests = 0;
        loads_sent = 0;
        results_seen = 0;
        held_valid = 1'b0;
        held_result = '0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        mark = errors;
        tick();
        check_value("valid after reset", result_valid_o, 0);
        check_value("ready after reset", dispatch_ready_o, 1);
        end_test("reset state", mark);

        mark = errors;
        send_op(OP_STORE, 3, 32'hCAFE_0003);
        drv_commit = 1'b1;
        tick();
        drv_commit = 1'b0;
        tick();
        send_op(OP_LOAD, 3, '0);
        wait_results();
        end_test("load from memory", mark);

        mark = errors;
        send_op(OP_STORE, 5, 32'h5555_AAAA);
        send_op(OP_LOAD, 5, '0);
        wait_results();
        drain_commits();
        end_test("store forwarding", mark);

        // Second older store wins, younger store stays hidden
        mark = errors;
        send_op(OP_STORE, 7, 32'h1111_0007);
        send_op(OP_STORE, 7, 32'h2222_0007);
        send_op(OP_LOAD, 7, '0);
        send_op(OP_STORE, 7, 32'h3333_0007);
        wait_results();
        drain_commits();
        end_test("youngest older store", mark);

        mark = errors;
        for (int i = 0; i < `MMU_SQ_DEPTH; i++) begin
            send_op(OP_STORE, i, 32'hF000_0000 + 32'(i));
        end
        present_op(OP_STORE, 8, 32'hF000_0008);
        repeat (3) begin
            tick();
            check_value("ready while store queue full", dispatch_ready_o, 0);
        end
        drv_commit = 1'b1;
        tick();
        drv_commit = 1'b0;
        wait_accept();
        drain_commits();
        drv_ready = 1'b0;
        send_op(OP_LOAD, 2, '0);
        wait_result_valid();
        held = result_o;
        repeat (4) tick();
        check_value("result under back-pressure", result_o, held);
        drv_ready = 1'b1;
        wait_results();
        end_test("full queue and back-pressure", mark);

        mark = errors;
        rand_mode = 1'b1;
        for (int i = 0; i < RAND_OPS; i++) begin
            w = $random(seed) & 15;
            d = $random(seed);
            if ((($random(seed) & 1) != 0) && written[w]) begin
                send_op(OP_LOAD, w, d);
            end else begin
                send_op(OP_STORE, w, d);
            end
            if (($random(seed) & 3) == 0) begin
                tick();
            end
        end
        wait_results();
        rand_mode = 1'b0;
        drv_ready = 1'b1;
        drain_commits();
        end_test("random mixed traffic", mark);

        chk_fails = u_mmu_top.u_load_queue.u_chk.violations +
                    u_mmu_top.u_store_queue.u_chk.violations;
        if (chk_fails != 0) begin
            $display("Queue checkers reported %0d assertion failures", chk_fails);
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d, loads %0d, results %0d",
                 tests, failed_tests, checks, errors + chk_fails, loads_sent, results_seen);
        if (errors == 0 && chk_fails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
